/* rtl/mac_pkg.sv */
package mac_pkg;

  // ********************
  // Dimensions
  // ********************

  localparam int MAT_DIM    = 4;
  localparam int ELEM_W     = 16;
  localparam int STEP_W     = 3;
  localparam int IDX_W      = $clog2(MAT_DIM);
  localparam int MUL_STAGES = 2;

  // Start edge to done edge
  localparam int ADD_LATENCY = 2;
  localparam int MUL_LATENCY = MUL_STAGES + 2;

  // ********************
  // Data types
  // ********************

  typedef logic signed [ELEM_W-1:0] elem_t;

  // Element [row][col]
  typedef elem_t [MAT_DIM-1:0][MAT_DIM-1:0] matrix_t;

  // Bit row*MAT_DIM + col
  typedef logic [MAT_DIM*MAT_DIM-1:0] mask_t;

  // ********************
  // Instruction
  // ********************

  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_EWMUL  = 2'd1,
    OP_MATMUL = 2'd2
  } op_t;

  typedef struct packed {
    op_t               op;
    logic              sub;
    logic              init_acc;
    logic [MAT_DIM-1:0] row_mask;
    logic [MAT_DIM-1:0] col_mask;
    logic [STEP_W-1:0] dim;
  } instr_t;

  // One step on its way through the datapath
  typedef struct packed {
    logic              valid;
    op_t               op;
    logic [STEP_W-1:0] step;
    logic              first;
    mask_t             mask;
  } issue_t;

endpackage

/* rtl/mac_ctrl.sv */
module mac_ctrl
  import mac_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_clear,
  input  logic   i_start,
  input  instr_t i_instr,
  output logic   o_busy,
  output logic   o_done,
  output issue_t o_issue
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_t;

  state_t            state_q;
  op_t               op_q;
  logic              init_acc_q;
  mask_t             mask_q;
  logic [STEP_W-1:0] nsteps_q;
  logic [STEP_W-1:0] step_q;
  logic [STEP_W-1:0] lat_q;
  logic              done_q;
  mask_t             start_mask;
  logic [STEP_W-1:0] start_nsteps;
  logic [STEP_W-1:0] start_lat;
  logic              issuing;

  always_comb
  begin
    for (int r = 0; r < MAT_DIM; r++)
    begin
      for (int c = 0; c < MAT_DIM; c++)
      begin
        start_mask[r*MAT_DIM+c] = i_instr.row_mask[r] & i_instr.col_mask[c];
      end
    end
  end

  // Matrix multiply runs one outer product per inner index
  always_comb
  begin
    case (i_instr.op)
      OP_MATMUL:
      begin
        start_nsteps = i_instr.dim;
        start_lat    = i_instr.dim + STEP_W'(MUL_LATENCY - 1);
      end
      OP_EWMUL:
      begin
        start_nsteps = STEP_W'(1);
        start_lat    = STEP_W'(MUL_LATENCY);
      end
      default:
      begin
        start_nsteps = STEP_W'(1);
        start_lat    = STEP_W'(ADD_LATENCY);
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      op_q       <= OP_ADD;
      init_acc_q <= 1'b0;
      mask_q     <= '0;
      nsteps_q   <= '0;
    end
    else if (i_start && state_q == ST_IDLE)
    begin
      op_q       <= i_instr.op;
      init_acc_q <= i_instr.init_acc;
      mask_q     <= start_mask;
      nsteps_q   <= start_nsteps;
    end
  end

  // ********************
  // Sequencer
  // ********************

  assign issuing = (state_q == ST_BUSY) && (step_q < nsteps_q);

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state_q <= ST_IDLE;
      step_q  <= '0;
      lat_q   <= '0;
      done_q  <= 1'b0;
    end
    else if (i_clear)
    begin
      state_q <= ST_IDLE;
      step_q  <= '0;
      lat_q   <= '0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (i_start)
          begin
            state_q <= ST_BUSY;
            step_q  <= '0;
            lat_q   <= start_lat;
          end
        end
        ST_BUSY:
        begin
          if (issuing)
            step_q <= step_q + STEP_W'(1);
          // Busy stays up through the done cycle
          if (done_q)
            state_q <= ST_IDLE;
          else
          begin
            lat_q  <= lat_q - STEP_W'(1);
            done_q <= (lat_q == STEP_W'(1));
          end
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  assign o_busy = (state_q == ST_BUSY);
  assign o_done = done_q;

  always_comb
  begin
    o_issue.valid = issuing;
    o_issue.op    = op_q;
    o_issue.step  = step_q;
    o_issue.first = (step_q == '0) && ((op_q != OP_MATMUL) || init_acc_q);
    o_issue.mask  = mask_q;
  end

  a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> !o_busy);

  a_dim_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_start && i_instr.op == OP_MATMUL) |-> (i_instr.dim inside {[1:MAT_DIM]}));

endmodule

/* rtl/operand_route.sv */
module operand_route
  import mac_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_clear,
  input  logic    i_start,
  input  instr_t  i_instr,
  input  matrix_t i_mat_a,
  input  matrix_t i_mat_b,
  input  issue_t  i_issue,
  output matrix_t o_mul_a,
  output matrix_t o_mul_b,
  output matrix_t o_add_a,
  output matrix_t o_add_b,
  output logic    o_sub,
  output issue_t  o_issue
);

  matrix_t          a_q;
  matrix_t          b_q;
  logic             sub_q;
  matrix_t          mul_a_d;
  matrix_t          mul_b_d;
  matrix_t          mul_a_q;
  matrix_t          mul_b_q;
  issue_t           issue_q;
  logic [IDX_W-1:0] k;

  // Operand capture at the start edge
  always_ff @(posedge i_clk)
  begin
    if (i_start)
    begin
      a_q <= i_mat_a;
      b_q <= i_mat_b;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      sub_q <= 1'b0;
    else if (i_start)
      sub_q <= i_instr.sub;
  end

  assign k = i_issue.step[IDX_W-1:0];

  // ********************
  // Step operands
  // ********************

  // Outer product k: column k of A times row k of B
  always_comb
  begin
    mul_a_d = a_q;
    mul_b_d = b_q;
    if (i_issue.op == OP_MATMUL)
    begin
      for (int m = 0; m < MAT_DIM; m++)
      begin
        for (int n = 0; n < MAT_DIM; n++)
        begin
          mul_a_d[m][n] = a_q[m][k];
          mul_b_d[m][n] = b_q[k][n];
        end
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_issue.valid)
    begin
      mul_a_q <= mul_a_d;
      mul_b_q <= mul_b_d;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      issue_q <= '0;
    else if (i_clear)
      issue_q <= '0;
    else
      issue_q <= i_issue;
  end

  assign o_mul_a = mul_a_q;
  assign o_mul_b = mul_b_q;
  assign o_add_a = a_q;
  assign o_add_b = b_q;
  assign o_sub   = sub_q;
  assign o_issue = issue_q;

endmodule

/* rtl/mul_array.sv */
module mul_array
  import mac_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_clear,
  input  matrix_t i_a,
  input  matrix_t i_b,
  input  issue_t  i_issue,
  output matrix_t o_prod,
  output issue_t  o_issue
);

  matrix_t prod_d;
  matrix_t prod_q  [MUL_STAGES];
  issue_t  issue_q [MUL_STAGES];

  // Wrapped result keeps only the low half of each product
  always_comb
  begin
    for (int m = 0; m < MAT_DIM; m++)
    begin
      for (int n = 0; n < MAT_DIM; n++)
      begin
        prod_d[m][n] = elem_t'(i_a[m][n] * i_b[m][n]);
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_issue.valid)
      prod_q[0] <= prod_d;
    for (int s = 1; s < MUL_STAGES; s++)
    begin
      if (issue_q[s-1].valid)
        prod_q[s] <= prod_q[s-1];
    end
  end

  // Issue tags ride alongside the products
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      for (int s = 0; s < MUL_STAGES; s++)
        issue_q[s] <= '0;
    end
    else if (i_clear)
    begin
      for (int s = 0; s < MUL_STAGES; s++)
        issue_q[s] <= '0;
    end
    else
    begin
      issue_q[0] <= i_issue;
      for (int s = 1; s < MUL_STAGES; s++)
        issue_q[s] <= issue_q[s-1];
    end
  end

  assign o_prod  = prod_q[MUL_STAGES-1];
  assign o_issue = issue_q[MUL_STAGES-1];

endmodule

/* rtl/acc_array.sv */
module acc_array
  import mac_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_clear,
  input  matrix_t i_add_a,
  input  matrix_t i_add_b,
  input  matrix_t i_prod,
  input  logic    i_sub,
  input  issue_t  i_add_issue,
  input  issue_t  i_mul_issue,
  output matrix_t o_result
);

  matrix_t acc_q;
  matrix_t acc_d;
  matrix_t rhs;
  logic    add_fire;
  logic    mul_fire;

  assign add_fire = i_add_issue.valid && (i_add_issue.op == OP_ADD);
  assign mul_fire = i_mul_issue.valid && (i_mul_issue.op != OP_ADD);

  // Subtract is A + ~B + 1
  always_comb
  begin
    for (int m = 0; m < MAT_DIM; m++)
    begin
      for (int n = 0; n < MAT_DIM; n++)
      begin
        rhs[m][n] = i_sub ? ~i_add_b[m][n] : i_add_b[m][n];
      end
    end
  end

  // ********************
  // Accumulator update
  // ********************

  always_comb
  begin
    acc_d = acc_q;
    for (int m = 0; m < MAT_DIM; m++)
    begin
      for (int n = 0; n < MAT_DIM; n++)
      begin
        if (add_fire && i_add_issue.mask[m*MAT_DIM+n])
          acc_d[m][n] = i_add_a[m][n] + rhs[m][n] + elem_t'(i_sub);
        else if (mul_fire && i_mul_issue.mask[m*MAT_DIM+n])
          // First step starts the sum from zero
          acc_d[m][n] = (i_mul_issue.first ? elem_t'(0) : acc_q[m][n]) + i_prod[m][n];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      acc_q <= '0;
    else if (!i_clear)
      acc_q <= acc_d;
  end

  assign o_result = acc_q;

  // Add results and products never land in the same cycle
  a_one_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(add_fire && mul_fire));

endmodule

/* rtl/matrix_mac.sv */
module matrix_mac
  import mac_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_clear,
  input  logic    i_start,
  input  instr_t  i_instr,
  input  matrix_t i_mat_a,
  input  matrix_t i_mat_b,
  output logic    o_busy,
  output logic    o_done,
  output mask_t   o_wenable,
  output matrix_t o_result
);

  issue_t  ctrl_issue;
  issue_t  route_issue;
  issue_t  mul_issue;
  matrix_t mul_a;
  matrix_t mul_b;
  matrix_t add_a;
  matrix_t add_b;
  matrix_t prod;
  logic    sub;

  mac_ctrl mac_ctrl_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_clear (i_clear),
    .i_start (i_start),
    .i_instr (i_instr),
    .o_busy  (o_busy),
    .o_done  (o_done),
    .o_issue (ctrl_issue)
  );

  operand_route operand_route_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_clear (i_clear),
    .i_start (i_start),
    .i_instr (i_instr),
    .i_mat_a (i_mat_a),
    .i_mat_b (i_mat_b),
    .i_issue (ctrl_issue),
    .o_mul_a (mul_a),
    .o_mul_b (mul_b),
    .o_add_a (add_a),
    .o_add_b (add_b),
    .o_sub   (sub),
    .o_issue (route_issue)
  );

  mul_array mul_array_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_clear (i_clear),
    .i_a     (mul_a),
    .i_b     (mul_b),
    .i_issue (route_issue),
    .o_prod  (prod),
    .o_issue (mul_issue)
  );

  acc_array acc_array_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_clear     (i_clear),
    .i_add_a     (add_a),
    .i_add_b     (add_b),
    .i_prod      (prod),
    .i_sub       (sub),
    .i_add_issue (route_issue),
    .i_mul_issue (mul_issue),
    .o_result    (o_result)
  );

  // Write map shown only in the done cycle
  assign o_wenable = o_done ? ctrl_issue.mask : '0;

endmodule

/* dv/mac_model.svh */
`ifndef MAC_MODEL_SVH
`define MAC_MODEL_SVH

// ********************
// Random source
// ********************

localparam logic [31:0] LFSR_SEED = 32'h2abe_3b9d;
// Right-shifting form of x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state;

function automatic logic [31:0] lfsr_next(logic [31:0] s);
  if (s[0])
    return (s >> 1) ^ LFSR_TAPS;
  return s >> 1;
endfunction

// One LFSR step per bit
// First bit taken ends up most significant
function automatic logic [31:0] take_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    v          = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// ********************
// Reference model
// ********************

function automatic mask_t write_mask(instr_t ins);
  mask_t m;
  for (int r = 0; r < MAT_DIM; r++)
  begin
    for (int c = 0; c < MAT_DIM; c++)
      m[r*MAT_DIM+c] = ins.row_mask[r] & ins.col_mask[c];
  end
  return m;
endfunction

function automatic int op_latency(instr_t ins);
  case (ins.op)
    OP_ADD:   return ADD_LATENCY;
    OP_EWMUL: return MUL_LATENCY;
    default:  return int'(ins.dim) + 3;
  endcase
endfunction

function automatic matrix_t model_result(matrix_t prev, matrix_t a, matrix_t b, instr_t ins);
  matrix_t res;
  elem_t   full;
  res = prev;
  for (int m = 0; m < MAT_DIM; m++)
  begin
    for (int n = 0; n < MAT_DIM; n++)
    begin
      case (ins.op)
        OP_ADD:   full = ins.sub ? a[m][n] - b[m][n] : a[m][n] + b[m][n];
        OP_EWMUL: full = a[m][n] * b[m][n];
        default:
        begin
          full = ins.init_acc ? elem_t'(0) : prev[m][n];
          for (int k = 0; k < int'(ins.dim); k++)
            full = full + a[m][k] * b[k][n];
        end
      endcase
      // Unmasked elements keep the old value
      if (ins.row_mask[m] && ins.col_mask[n])
        res[m][n] = full;
    end
  end
  return res;
endfunction

`endif

/* dv/matrix_mac_tb.sv */
module matrix_mac_tb
  import mac_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DONE_TIMEOUT = 32;
  localparam int QUIET_CYCLES = 6;
  localparam int WAIT_LIMIT   = 200;

  typedef struct packed {
    matrix_t    result;
    mask_t      mask;
    logic [7:0] latency;
    logic       aborted;
  } expect_t;

  logic    clk;
  logic    i_rst_n;
  logic    i_clear;
  logic    i_start;
  instr_t  i_instr;
  matrix_t i_mat_a;
  matrix_t i_mat_b;
  logic    o_busy;
  logic    o_done;
  mask_t   o_wenable;
  matrix_t o_result;

  expect_t exp_q [$];
  matrix_t model_acc;
  int      n_issued;
  int      n_checked;

  `include "mac_model.svh"

  matrix_mac matrix_mac_inst (
    .i_clk     (clk),
    .i_rst_n   (i_rst_n),
    .i_clear   (i_clear),
    .i_start   (i_start),
    .i_instr   (i_instr),
    .i_mat_a   (i_mat_a),
    .i_mat_b   (i_mat_b),
    .o_busy    (o_busy),
    .o_done    (o_done),
    .o_wenable (o_wenable),
    .o_result  (o_result)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ********************
  // Checks
  // ********************

  task automatic fail_now();
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_matrix(string name, matrix_t got, matrix_t exp);
    logic found;
    found = 1'b0;
    for (int m = 0; m < MAT_DIM; m++)
    begin
      for (int n = 0; n < MAT_DIM; n++)
      begin
        if (!found && got[m][n] !== exp[m][n])
        begin
          $display("Error %s[%0d][%0d]: got 0x%h, expected 0x%h",
                   name, m, n, got[m][n], exp[m][n]);
          found = 1'b1;
        end
      end
    end
    if (found)
      fail_now();
  endtask

  task automatic check_mask(string name, mask_t got, mask_t exp);
    if (got !== exp)
    begin
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp)
    begin
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_now();
    end
  endtask

  // ********************
  // Stimulus helpers
  // ********************

  function automatic matrix_t rand_matrix();
    matrix_t     m;
    logic [31:0] v;
    for (int r = 0; r < MAT_DIM; r++)
    begin
      for (int c = 0; c < MAT_DIM; c++)
      begin
        v       = take_bits(ELEM_W);
        m[r][c] = v[ELEM_W-1:0];
      end
    end
    return m;
  endfunction

  function automatic instr_t make_instr(op_t op, logic sub, logic init_acc,
                                        logic [3:0] rows, logic [3:0] cols, logic [2:0] dim);
    instr_t ins;
    ins.op       = op;
    ins.sub      = sub;
    ins.init_acc = init_acc;
    ins.row_mask = rows;
    ins.col_mask = cols;
    ins.dim      = dim;
    return ins;
  endfunction

  function automatic instr_t random_instr();
    instr_t      ins;
    logic [31:0] v;
    ins = '0;
    v = take_bits(2);
    case (v[1:0])
      2'd0:    ins.op = OP_ADD;
      2'd1:    ins.op = OP_EWMUL;
      default: ins.op = OP_MATMUL;
    endcase
    v = take_bits(1);
    ins.sub = v[0];
    v = take_bits(1);
    ins.init_acc = v[0];
    v = take_bits(4);
    ins.row_mask = v[3:0];
    v = take_bits(4);
    ins.col_mask = v[3:0];
    v = take_bits(2);
    ins.dim = 3'(v[1:0]) + 3'd1;
    return ins;
  endfunction

  // Drives the start strobe, queues what the compare process expects
  task automatic issue_instr(instr_t ins, matrix_t a, matrix_t b, logic aborted);
    expect_t e;
    if (!aborted)
      model_acc = model_result(model_acc, a, b, ins);
    e.result  = model_acc;
    e.mask    = write_mask(ins);
    e.latency = 8'(op_latency(ins));
    e.aborted = aborted;
    @(posedge clk);
    i_start <= 1'b1;
    i_instr <= ins;
    i_mat_a <= a;
    i_mat_b <= b;
    exp_q.push_back(e);
    n_issued++;
    @(posedge clk);
    i_start <= 1'b0;
  endtask

  task automatic wait_checked();
    int n;
    n = 0;
    while (n_checked != n_issued)
    begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
      begin
        $display("Timeout: the last instruction was never checked");
        fail_now();
      end
    end
  endtask

  task automatic run_instr(instr_t ins);
    matrix_t a;
    matrix_t b;
    a = rand_matrix();
    b = rand_matrix();
    issue_instr(ins, a, b, 1'b0);
    wait_checked();
  endtask

  task automatic abort_instr(instr_t ins, int clear_after);
    matrix_t a;
    matrix_t b;
    a = rand_matrix();
    b = rand_matrix();
    issue_instr(ins, a, b, 1'b1);
    repeat (clear_after) @(posedge clk);
    i_clear <= 1'b1;
    @(posedge clk);
    i_clear <= 1'b0;
    wait_checked();
  endtask

  // ********************
  // Compare process
  // ********************

  initial
  begin : compare
    expect_t cur;
    logic    tracking;
    logic    cleared;
    int      edges;
    int      quiet;
    cur      = '0;
    tracking = 1'b0;
    cleared  = 1'b0;
    edges    = 0;
    quiet    = 0;
    forever
    begin
      @(negedge clk);
      if (i_rst_n)
      begin
        if (!tracking)
        begin
          check_bit("o_busy", o_busy, 1'b0);
          check_bit("o_done", o_done, 1'b0);
          check_mask("o_wenable", o_wenable, '0);
          if (i_start)
          begin
            if (exp_q.size() == 0)
            begin
              $display("A start arrived with no expected result queued");
              fail_now();
            end
            cur      = exp_q[0];
            tracking = 1'b1;
            cleared  = 1'b0;
            // Start edge is the next rising edge
            edges    = -1;
            quiet    = 0;
          end
        end
        else if (cleared)
        begin
          quiet++;
          check_bit("o_busy", o_busy, 1'b0);
          check_bit("o_done", o_done, 1'b0);
          check_matrix("o_result", o_result, cur.result);
          if (quiet == QUIET_CYCLES)
          begin
            void'(exp_q.pop_front());
            tracking = 1'b0;
            n_checked++;
          end
        end
        else
        begin
          edges++;
          check_bit("o_busy", o_busy, 1'b1);
          if (o_done)
          begin
            if (cur.aborted)
            begin
              $display("o_done arrived for an instruction that was meant to be cleared");
              fail_now();
            end
            check_count("latency", edges, int'(cur.latency));
            check_mask("o_wenable", o_wenable, cur.mask);
            check_matrix("o_result", o_result, cur.result);
            void'(exp_q.pop_front());
            tracking = 1'b0;
            n_checked++;
          end
          else
          begin
            check_mask("o_wenable", o_wenable, '0);
            if (edges > DONE_TIMEOUT)
            begin
              $display("Timeout: o_done did not arrive within %0d cycles", DONE_TIMEOUT);
              fail_now();
            end
            if (i_clear)
              cleared = 1'b1;
          end
        end
      end
    end
  end

  // ********************
  // Stimulus
  // ********************

  initial
  begin : stimulus
    i_rst_n    = 1'b0;
    i_clear    = 1'b0;
    i_start    = 1'b0;
    i_instr    = '0;
    i_mat_a    = '0;
    i_mat_b    = '0;
    lfsr_state = LFSR_SEED;
    model_acc  = '0;
    n_issued   = 0;
    n_checked  = 0;
    repeat (10) @(posedge clk);
    i_rst_n <= 1'b1;
    @(negedge clk);
    check_matrix("o_result", o_result, '0);

    // Add and subtract, full masks
    for (int i = 0; i < 6; i++)
      run_instr(make_instr(OP_ADD, i[0], 1'b0, 4'hf, 4'hf, 3'd1));

    for (int i = 0; i < 4; i++)
      run_instr(make_instr(OP_EWMUL, 1'b0, 1'b0, 4'hf, 4'hf, 3'd1));

    // Matrix multiply from zero, every inner dimension
    for (int d = 1; d <= MAT_DIM; d++)
      run_instr(make_instr(OP_MATMUL, 1'b0, 1'b1, 4'hf, 4'hf, 3'(d)));

    // Accumulate onto the previous result
    run_instr(make_instr(OP_MATMUL, 1'b0, 1'b0, 4'hf, 4'hf, 3'd4));
    run_instr(make_instr(OP_MATMUL, 1'b0, 1'b0, 4'hf, 4'hf, 3'd2));
    run_instr(make_instr(OP_MATMUL, 1'b0, 1'b0, 4'hf, 4'hf, 3'd3));

    for (int i = 0; i < 40; i++)
      run_instr(random_instr());

    // Clear in flight, before anything reaches the accumulator
    abort_instr(make_instr(OP_MATMUL, 1'b0, 1'b1, 4'hf, 4'hf, 3'd4), 1);
    run_instr(make_instr(OP_MATMUL, 1'b0, 1'b0, 4'hf, 4'hf, 3'd3));
    abort_instr(make_instr(OP_ADD, 1'b1, 1'b0, 4'hf, 4'hf, 3'd1), 0);
    abort_instr(make_instr(OP_EWMUL, 1'b0, 1'b0, 4'h5, 4'hf, 3'd1), 2);
    run_instr(make_instr(OP_ADD, 1'b0, 1'b0, 4'h6, 4'h9, 3'd1));

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+dv
rtl/mac_pkg.sv
rtl/mac_ctrl.sv
rtl/operand_route.sv
rtl/mul_array.sv
rtl/acc_array.sv
rtl/matrix_mac.sv
dv/matrix_mac_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the matrix_mac testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module matrix_mac_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed"
  exit "$status"
fi

./obj_dir/Vmatrix_mac_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit "$status"
fi

exit 0
